// File: rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;
  localparam int pc_step = 4;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011
  } opcode_e;

  // one-hot classification of what sits in writeback each cycle
  typedef enum logic [31:0] {
    cycle_invalid      = 32'd0,
    cycle_reset        = 32'd1,
    cycle_no_stall     = 32'd2,
    cycle_taken_branch = 32'd4
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_stage_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         a;
    word_t         b;
    logic          writes_rd;
    cycle_status_e status;
  } execute_stage_t;

  // shared by the memory and writeback registers
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         o;
    logic          writes_rd;
    cycle_status_e status;
  } wb_stage_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     value;
    logic      valid;
  } bypass_t;

  // what leaves writeback every cycle
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    reg_addr_t     rd;
    word_t         data;
    logic          we;
  } trace_t;

endpackage

// File: rv_fetch.sv
module rv_fetch (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         insn,
  input  rv_pkg::redirect_t     redirect,
  output rv_pkg::word_t         pc_to_imem,
  output rv_pkg::decode_stage_t decode_state
);

  rv_pkg::word_t pc;

  // imem answers in the same cycle
  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else begin
      pc <= pc + rv_pkg::word_t'(rv_pkg::pc_step);
    end
  end

  // the word fetched alongside a taken redirect is on the wrong path
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_state <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset};
    end else if (redirect.taken) begin
      decode_state <= '{pc: '0, insn: '0, status: rv_pkg::cycle_taken_branch};
    end else begin
      decode_state <= '{pc: pc, insn: insn, status: rv_pkg::cycle_no_stall};
    end
  end

endmodule

// File: rv_regfile.sv
module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  logic              we
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: rv_decode.sv
module rv_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pkg::decode_stage_t  decode_state,
  input  rv_pkg::redirect_t      redirect,
  input  rv_pkg::bypass_t        wb_bypass,
  output rv_pkg::reg_addr_t      rs1,
  output rv_pkg::reg_addr_t      rs2,
  input  rv_pkg::word_t          rs1_data,
  input  rv_pkg::word_t          rs2_data,
  output rv_pkg::execute_stage_t execute_state
);

  rv_pkg::opcode_e op;
  rv_pkg::word_t   a;
  rv_pkg::word_t   b;
  logic            writes_rd;

  assign op  = rv_pkg::opcode_e'(decode_state.insn[6:0]);
  assign rs1 = decode_state.insn[19:15];
  assign rs2 = decode_state.insn[24:20];

  // the register file is written at the end of this cycle, so forward the
  // value that writeback is about to commit
  always_comb begin
    if (wb_bypass.valid && wb_bypass.rd == rs1) begin
      a = wb_bypass.value;
    end else begin
      a = rs1_data;
    end
    if (wb_bypass.valid && wb_bypass.rd == rs2) begin
      b = wb_bypass.value;
    end else begin
      b = rs2_data;
    end
  end

  // branches carry immediate bits in the rd field
  assign writes_rd = (decode_state.status == rv_pkg::cycle_no_stall) &&
                     (op != rv_pkg::op_branch);

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{pc: '0, insn: '0, a: '0, b: '0, writes_rd: 1'b0,
                         status: rv_pkg::cycle_reset};
    end else if (redirect.taken) begin
      execute_state <= '{pc: '0, insn: '0, a: '0, b: '0, writes_rd: 1'b0,
                         status: rv_pkg::cycle_taken_branch};
    end else begin
      execute_state <= '{pc: decode_state.pc, insn: decode_state.insn, a: a, b: b,
                         writes_rd: writes_rd, status: decode_state.status};
    end
  end

endmodule

// File: rv_execute.sv
module rv_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pkg::execute_stage_t execute_state,
  input  rv_pkg::bypass_t        wb_bypass,
  output rv_pkg::redirect_t      redirect,
  output rv_pkg::wb_stage_t      memory_state
);

  rv_pkg::bypass_t mem_bypass;
  rv_pkg::opcode_e op;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   insn;
  rv_pkg::word_t   a;
  rv_pkg::word_t   b;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   link;
  rv_pkg::word_t   result;
  logic [63:0]     mul_a;
  logic [63:0]     mul_b;
  logic [63:0]     product;
  logic            take_branch;

  // the newest producer wins since memory is one instruction younger than writeback
  function automatic rv_pkg::word_t pick_operand(rv_pkg::reg_addr_t src, rv_pkg::word_t held,
                                                 rv_pkg::bypass_t mem, rv_pkg::bypass_t wb);
    rv_pkg::word_t val;
    val = held;
    if (wb.valid && wb.rd == src) begin
      val = wb.value;
    end
    if (mem.valid && mem.rd == src) begin
      val = mem.value;
    end
    return val;
  endfunction

  assign mem_bypass = '{rd: memory_state.insn[11:7], value: memory_state.o,
                        valid: memory_state.writes_rd && memory_state.insn[11:7] != '0};

  assign insn   = execute_state.insn;
  assign op     = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign a      = pick_operand(insn[19:15], execute_state.a, mem_bypass, wb_bypass);
  assign b      = pick_operand(insn[24:20], execute_state.b, mem_bypass, wb_bypass);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign link  = execute_state.pc + rv_pkg::word_t'(rv_pkg::pc_step);

  // one 64-bit multiplier with operands sign-extended per variant
  // mulh signs both, mulhsu only rs1, mul and mulhu neither
  assign mul_a   = {{32{a[31] & (funct3 == 3'b001 || funct3 == 3'b010)}}, a};
  assign mul_b   = {{32{b[31] & (funct3 == 3'b001)}}, b};
  assign product = mul_a * mul_b;

  always_comb begin
    case (funct3)
      3'b000:  take_branch = a == b;
      3'b001:  take_branch = a != b;
      3'b100:  take_branch = $signed(a) < $signed(b);
      3'b101:  take_branch = $signed(a) >= $signed(b);
      3'b110:  take_branch = a < b;
      3'b111:  take_branch = a >= b;
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    result = '0;
    redirect = '{taken: 1'b0, target: '0};
    case (op)
      rv_pkg::op_lui: begin
        result = {insn[31:12], 12'b0};
      end
      rv_pkg::op_jal: begin
        result = link;
        redirect = '{taken: 1'b1, target: execute_state.pc + imm_j};
      end
      rv_pkg::op_jalr: begin
        result = link;
        redirect = '{taken: 1'b1, target: (a + imm_i) & ~rv_pkg::word_t'(1)};
      end
      rv_pkg::op_branch: begin
        redirect = '{taken: take_branch, target: execute_state.pc + imm_b};
      end
      rv_pkg::op_reg_imm: begin
        case (funct3)
          3'b000:  result = a + imm_i;
          3'b010:  result = {31'b0, $signed(a) < $signed(imm_i)};
          3'b011:  result = {31'b0, a < imm_i};
          3'b100:  result = a ^ imm_i;
          3'b110:  result = a | imm_i;
          3'b111:  result = a & imm_i;
          3'b001:  result = a << imm_i[4:0];
          default: begin
            if (insn[30]) begin
              result = $signed(a) >>> imm_i[4:0];
            end else begin
              result = a >> imm_i[4:0];
            end
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        if (funct7 == 7'b0000001) begin
          // divide variants are not implemented and yield zero
          case (funct3)
            3'b000:                 result = product[31:0];
            3'b001, 3'b010, 3'b011: result = product[63:32];
            default:                result = '0;
          endcase
        end else begin
          case (funct3)
            3'b000:  result = insn[30] ? a - b : a + b;
            3'b001:  result = a << b[4:0];
            3'b010:  result = {31'b0, $signed(a) < $signed(b)};
            3'b011:  result = {31'b0, a < b};
            3'b100:  result = a ^ b;
            3'b101: begin
              if (insn[30]) begin
                result = $signed(a) >>> b[4:0];
              end else begin
                result = a >> b[4:0];
              end
            end
            3'b110:  result = a | b;
            default: result = a & b;
          endcase
        end
      end
      default: begin
        result = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{pc: '0, insn: '0, o: '0, writes_rd: 1'b0,
                        status: rv_pkg::cycle_reset};
    end else begin
      memory_state <= '{pc: execute_state.pc, insn: insn, o: result,
                        writes_rd: execute_state.writes_rd, status: execute_state.status};
    end
  end

endmodule

// File: rv_writeback.sv
module rv_writeback (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::wb_stage_t memory_state,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     rd_data,
  output logic              we,
  output rv_pkg::bypass_t   wb_bypass,
  output rv_pkg::trace_t    trace
);

  rv_pkg::wb_stage_t writeback_state;

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_state <= '{pc: '0, insn: '0, o: '0, writes_rd: 1'b0,
                           status: rv_pkg::cycle_reset};
    end else begin
      writeback_state <= memory_state;
    end
  end

  assign rd      = writeback_state.insn[11:7];
  assign rd_data = writeback_state.o;
  // x0 writes are dropped here so bypass and trace agree with the register file
  assign we      = writeback_state.writes_rd && rd != '0;

  assign wb_bypass = '{rd: rd, value: rd_data, valid: we};

  assign trace = '{pc: writeback_state.pc, insn: writeback_state.insn,
                   status: writeback_state.status, rd: rd, data: rd_data, we: we};

endmodule

// File: rv_core.sv
module rv_core (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::word_t  insn_from_imem,
  output rv_pkg::word_t  pc_to_imem,
  output rv_pkg::trace_t trace
);

  rv_pkg::decode_stage_t  decode_state;
  rv_pkg::execute_stage_t execute_state;
  rv_pkg::wb_stage_t      memory_state;
  rv_pkg::redirect_t      redirect;
  rv_pkg::bypass_t        wb_bypass;
  rv_pkg::reg_addr_t      rs1;
  rv_pkg::reg_addr_t      rs2;
  rv_pkg::word_t          rs1_data;
  rv_pkg::word_t          rs2_data;
  rv_pkg::reg_addr_t      rf_rd;
  rv_pkg::word_t          rf_rd_data;
  logic                   rf_we;

  rv_fetch fetch_inst (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn_from_imem),
    .redirect     (redirect),
    .pc_to_imem   (pc_to_imem),
    .decode_state (decode_state)
  );

  rv_decode decode_inst (
    .clk           (clk),
    .rst           (rst),
    .decode_state  (decode_state),
    .redirect      (redirect),
    .wb_bypass     (wb_bypass),
    .rs1           (rs1),
    .rs2           (rs2),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .execute_state (execute_state)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (rf_rd),
    .rd_data  (rf_rd_data),
    .we       (rf_we)
  );

  rv_execute execute_inst (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .wb_bypass     (wb_bypass),
    .redirect      (redirect),
    .memory_state  (memory_state)
  );

  rv_writeback writeback_inst (
    .clk          (clk),
    .rst          (rst),
    .memory_state (memory_state),
    .rd           (rf_rd),
    .rd_data      (rf_rd_data),
    .we           (rf_we),
    .wb_bypass    (wb_bypass),
    .trace        (trace)
  );

endmodule

// File: rv_core_checker.sv
module rv_core_checker (
  input logic           clk,
  input logic           rst,
  input rv_pkg::word_t  pc_to_imem,
  input rv_pkg::trace_t trace
);

  status_valid: assert property (@(posedge clk) disable iff (rst)
    trace.status != rv_pkg::cycle_invalid)
    else $error("trace status is invalid after reset");

  // bubbles and reset cycles never write the register file
  no_write_on_bubble: assert property (@(posedge clk) disable iff (rst)
    (trace.status != rv_pkg::cycle_no_stall) |-> !trace.we)
    else $error("write enable seen on a cycle without an instruction");

  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc_to_imem[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

  no_reset_after_branch: assert property (@(posedge clk) disable iff (rst)
    (trace.status == rv_pkg::cycle_taken_branch) |=> (trace.status != rv_pkg::cycle_reset))
    else $error("reset status followed a taken branch");

endmodule

bind rv_core rv_core_checker checker_inst (
  .clk        (clk),
  .rst        (rst),
  .pc_to_imem (pc_to_imem),
  .trace      (trace)
);

// File: rv_core_tb.sv
module rv_core_tb;

  logic                  clk;
  logic                  rst;
  rv_pkg::word_t         insn_from_imem;
  rv_pkg::word_t         pc_to_imem;
  rv_pkg::trace_t        trace;

  // program image and expected writeback records
  rv_pkg::word_t         prog [0:255];
  logic [31:0]           nprog;
  rv_pkg::trace_t        exp_q [$];
  logic                  loaded;
  int                    limit;
  int                    cycles;

  rv_core rv_core_inst (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .trace          (trace)
  );

  // instruction memory answers in the same cycle and returns a nop past the program
  always_comb begin
    if (pc_to_imem[31:2] < nprog[29:0]) begin
      insn_from_imem = prog[pc_to_imem[9:2]];
    end else begin
      insn_from_imem = 32'h00000013;
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic load_golden();
    integer         fd;
    integer         code;
    string          tag;
    string          rest;
    logic [31:0]    f0;
    logic [31:0]    f1;
    logic [31:0]    f2;
    logic [31:0]    f3;
    logic [31:0]    f4;
    logic [31:0]    f5;
    rv_pkg::trace_t rec;
    logic           done;
    fd = $fopen("rv_core_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file rv_core_golden.txt");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        done = 1'b1;
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h", f0);
        prog[nprog[7:0]] = f0;
        nprog = nprog + 32'd1;
      end else if (tag == "T") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
        rec = '{pc: f1, insn: f2, status: rv_pkg::cycle_status_e'(f0),
                rd: f3[4:0], data: f4, we: f5[0]};
        exp_q.push_back(rec);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    string name;
    rst    = 1'b1;
    nprog  = 32'd0;
    loaded = 1'b0;
    load_golden();
    limit  = exp_q.size() + 20;
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // one record per cycle, sampled mid-cycle while trace is stable
    for (int i = 0; i < exp_q.size(); i++) begin
      @(negedge clk);
      name = $sformatf("trace cycle %0d", i);
      assert (trace == exp_q[i]) else begin
        $display("Fail %s expected %h actual %h", name, exp_q[i], trace);
        $display("ERRORS FOUND");
        $fatal(1);
      end
    end
    if (exp_q.size() == 0) begin
      $display("the golden file held no trace records");
      $display("ERRORS FOUND");
      $fatal(1);
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // watchdog sized from the number of expected records
  initial begin
    cycles = 0;
    wait (loaded);
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("run timed out after %0d cycles", cycles);
        $display("ERRORS FOUND");
        $fatal(1);
      end
    end
  end

endmodule

// File: rv_core_golden.txt
# P word : program word at the next word address, from 0
# T status pc insn rd data we : expected trace each cycle after reset, all hex
P 00500093
P ffd08113
P 022081b3
P 40118233
P fffff2b7
P 02129333
P 00120463
P 00100393
P 0080046f
P 00200393
P 00121463
P 00708013
P 005004b3
P 01840567
P 00300593
P 4044d613
T 1 00000000 00000000 00 00000000 0
T 1 00000000 00000000 00 00000000 0
T 1 00000000 00000000 00 00000000 0
T 1 00000000 00000000 00 00000000 0
T 2 00000000 00500093 01 00000005 1
T 2 00000004 ffd08113 02 00000002 1
T 2 00000008 022081b3 03 0000000a 1
T 2 0000000c 40118233 04 00000005 1
T 2 00000010 fffff2b7 05 fffff000 1
T 2 00000014 02129333 06 ffffffff 1
T 2 00000018 00120463 08 00000000 0
T 4 00000000 00000000 00 00000000 0
T 4 00000000 00000000 00 00000000 0
T 2 00000020 0080046f 08 00000024 1
T 4 00000000 00000000 00 00000000 0
T 4 00000000 00000000 00 00000000 0
T 2 00000028 00121463 08 00000000 0
T 2 0000002c 00708013 00 0000000c 0
T 2 00000030 005004b3 09 fffff000 1
T 2 00000034 01840567 0a 00000038 1
T 4 00000000 00000000 00 00000000 0
T 4 00000000 00000000 00 00000000 0
T 2 0000003c 4044d613 0c ffffff00 1

// File: files.f
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
rv_core_checker.sv
rv_core_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the rv_core testbench with Verilator
verilator --binary --timing --assert --top-module rv_core_tb -f files.f -o sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log && exit 0 || exit 1
